//--- src/dreq_params.svh
`ifndef DREQ_PARAMS_SVH
`define DREQ_PARAMS_SVH

// number of request sources merged onto the host stream.
`define DREQ_N_DESTS 4

// width of a source index, log2 of the destination count.
`define DREQ_DEST_BITS 2

// virtual address carried by each read request.
`define DREQ_VADDR_BITS 48

// transfer length in bytes.
`define DREQ_LEN_BITS 28

// entries per input queue.
`define DREQ_Q_DEPTH 4

`endif

//--- src/dreq_pkg.sv
`include "dreq_params.svh"

package dreq_pkg;

  // one read request as issued by a destination.
  typedef struct packed {
    logic [`DREQ_VADDR_BITS-1:0] vaddr;
    logic [`DREQ_LEN_BITS-1:0]   len;
    // stream transfer instead of memory mapped.
    logic                        strm;
    // last request of a larger transfer.
    logic                        last;
  } dreq_t;

  // request on the merged stream, tagged with where it came from.
  typedef struct packed {
    dreq_t                      req;
    logic [`DREQ_DEST_BITS-1:0] dest;
  } dreq_tag_t;

  // register map of the configuration block.
  // counters follow the enable mask at consecutive addresses.
  typedef enum logic [2:0] {
    REG_ENABLE     = 3'd0,
    REG_GRANT_CNT0 = 3'd1,
    REG_GRANT_CNT1 = 3'd2,
    REG_GRANT_CNT2 = 3'd3,
    REG_GRANT_CNT3 = 3'd4
  } cfg_addr_e;

  // configuration access, qualified by a single-cycle strobe.
  typedef struct packed {
    logic        wr;
    cfg_addr_e   addr;
    logic [31:0] data;
  } cfg_req_t;

  // one accepted grant, reported in the cycle of the handshake.
  typedef struct packed {
    logic                       valid;
    logic [`DREQ_DEST_BITS-1:0] dest;
  } grant_t;

endpackage

//--- src/dreq_in_queue.sv
`include "dreq_params.svh"

module dreq_in_queue (
  input  logic            aclk,
  input  logic            aresetn,
  input  logic            s_valid,
  output logic            s_ready,
  input  dreq_pkg::dreq_t s_data,
  output logic            m_valid,
  input  logic            m_ready,
  output dreq_pkg::dreq_t m_data
);

  localparam int DEPTH    = `DREQ_Q_DEPTH;
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  // circular storage addressed by the two pointers.
  dreq_pkg::dreq_t mem [DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                full;
  logic                push;
  logic                pop;

  // next slot wraps back to zero after the last entry.
  function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
    return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full    = (count == CNT_BITS'(DEPTH));
  assign m_valid = (count != '0);
  // when full, a pop in the same cycle frees the slot being written.
  assign s_ready = !full || m_ready;
  assign push    = s_valid && s_ready;
  assign pop     = m_valid && m_ready;
  // head of the queue is always presented.
  assign m_data  = mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= s_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // occupancy only changes when one side moves alone.
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/meta_reg.sv
module meta_reg (
  input  logic                aclk,
  input  logic                aresetn,
  input  logic                s_valid,
  output logic                s_ready,
  input  dreq_pkg::dreq_tag_t s_data,
  output logic                m_valid,
  input  logic                m_ready,
  output dreq_pkg::dreq_tag_t m_data
);

  // main register drives the output, spare catches the skid.
  logic                main_valid;
  logic                spare_valid;
  dreq_pkg::dreq_tag_t main_data;
  dreq_pkg::dreq_tag_t spare_data;
  logic                main_free;
  logic                load_main;
  logic                load_spare;
  logic                spare_to_main;

  // ready comes straight from a flop, no path from m_ready.
  assign s_ready = !spare_valid;
  assign m_valid = main_valid;
  assign m_data  = main_data;

  // main can take a new word when empty or draining this cycle.
  assign main_free     = !main_valid || m_ready;
  assign load_main     = !spare_valid && main_free && s_valid;
  assign load_spare    = !spare_valid && !main_free && s_valid;
  assign spare_to_main = spare_valid && m_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      main_valid  <= 1'b0;
      spare_valid <= 1'b0;
    end else begin
      if (spare_to_main) begin
        // main stays valid, refilled from the spare.
        spare_valid <= 1'b0;
      end else if (!spare_valid) begin
        if (main_free) begin
          main_valid <= s_valid;
        end else if (s_valid) begin
          spare_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (spare_to_main) begin
      main_data <= spare_data;
    end else if (load_main) begin
      main_data <= s_data;
    end
    if (load_spare) begin
      spare_data <= s_data;
    end
  end

endmodule

//--- src/dest_dreq_rd_arb.sv
`include "dreq_params.svh"

module dest_dreq_rd_arb (
  input  logic                                 aclk,
  input  logic                                 aresetn,
  input  logic            [`DREQ_N_DESTS-1:0]  s_valid,
  output logic            [`DREQ_N_DESTS-1:0]  s_ready,
  input  dreq_pkg::dreq_t [`DREQ_N_DESTS-1:0]  s_data,
  input  logic            [`DREQ_N_DESTS-1:0]  enable,
  output dreq_pkg::grant_t                     grant,
  output logic                                 m_valid,
  input  logic                                 m_ready,
  output dreq_pkg::dreq_tag_t                  m_data
);

  localparam int N_DESTS   = `DREQ_N_DESTS;
  localparam int DEST_BITS = `DREQ_DEST_BITS;

  logic [N_DESTS-1:0]   eligible;
  logic [DEST_BITS-1:0] rr_ptr;
  logic [DEST_BITS-1:0] win_idx;
  logic                 win_valid;
  logic                 slice_ready;
  logic                 slice_hs;
  dreq_pkg::dreq_tag_t  slice_data;

  // a paused destination is simply not a candidate.
  assign eligible = s_valid & enable;

  // search from the pointer, wrapping, first eligible wins.
  always_comb begin
    logic [DEST_BITS-1:0] cand;
    win_valid = 1'b0;
    win_idx   = '0;
    cand      = '0;
    for (int i = 0; i < N_DESTS; i++) begin
      cand = DEST_BITS'((int'(rr_ptr) + i) % N_DESTS);
      if (!win_valid && eligible[cand]) begin
        win_valid = 1'b1;
        win_idx   = cand;
      end
    end
  end

  // only the winner sees the slice ready.
  always_comb begin
    s_ready          = '0;
    s_ready[win_idx] = win_valid && slice_ready;
  end

  assign slice_data.req  = s_data[win_idx];
  assign slice_data.dest = win_idx;
  assign slice_hs        = win_valid && slice_ready;

  // grant is reported on the handshake into the slice.
  assign grant.valid = slice_hs;
  assign grant.dest  = win_idx;

  // pointer steps by one per accepted grant, not to the winner.
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr_ptr <= '0;
    end else if (slice_hs) begin
      if (rr_ptr == DEST_BITS'(N_DESTS - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= rr_ptr + 1'b1;
      end
    end
  end

  // output slice, breaks the ready path back into the queues.
  meta_reg inst_src_reg (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (win_valid),
    .s_ready (slice_ready),
    .s_data  (slice_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

endmodule

//--- src/dreq_cfg_regs.sv
`include "dreq_params.svh"

module dreq_cfg_regs (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  logic                       cfg_strobe,
  input  dreq_pkg::cfg_req_t         cfg_req,
  output logic                       cfg_rd_valid,
  output logic [31:0]                cfg_rd_data,
  output logic [`DREQ_N_DESTS-1:0]   enable,
  input  dreq_pkg::grant_t           grant
);

  localparam int N_DESTS = `DREQ_N_DESTS;

  logic [31:0] grant_cnt [N_DESTS];
  logic        wr_en;
  logic        rd_en;
  logic [31:0] rd_mux;

  assign wr_en = cfg_strobe && cfg_req.wr;
  assign rd_en = cfg_strobe && !cfg_req.wr;

  // all destinations run after reset.
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      enable <= '1;
    end else if (wr_en && cfg_req.addr == dreq_pkg::REG_ENABLE) begin
      enable <= cfg_req.data[N_DESTS-1:0];
    end
  end

  // grant counters, a write to a counter address clears it.
  // a clear wins over a grant landing in the same cycle.
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      for (int i = 0; i < N_DESTS; i++) begin
        grant_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N_DESTS; i++) begin
        if (wr_en && int'(cfg_req.addr) == int'(dreq_pkg::REG_GRANT_CNT0) + i) begin
          grant_cnt[i] <= '0;
        end else if (grant.valid && int'(grant.dest) == i) begin
          grant_cnt[i] <= grant_cnt[i] + 32'd1;
        end
      end
    end
  end

  // read-back select, unmapped addresses give zero.
  always_comb begin
    rd_mux = '0;
    if (cfg_req.addr == dreq_pkg::REG_ENABLE) begin
      rd_mux = 32'(enable);
    end
    for (int i = 0; i < N_DESTS; i++) begin
      if (int'(cfg_req.addr) == int'(dreq_pkg::REG_GRANT_CNT0) + i) begin
        rd_mux = grant_cnt[i];
      end
    end
  end

  // read data lands one cycle after the strobe.
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cfg_rd_valid <= 1'b0;
    end else begin
      cfg_rd_valid <= rd_en;
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_en) begin
      cfg_rd_data <= rd_mux;
    end
  end

endmodule

//--- src/dreq_rd_mux_top.sv
`include "dreq_params.svh"

module dreq_rd_mux_top (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  logic            [`DREQ_N_DESTS-1:0] s_req_valid,
  output logic            [`DREQ_N_DESTS-1:0] s_req_ready,
  input  dreq_pkg::dreq_t [`DREQ_N_DESTS-1:0] s_req_data,
  output logic                                m_req_valid,
  input  logic                                m_req_ready,
  output dreq_pkg::dreq_tag_t                 m_req_data,
  input  logic                                cfg_strobe,
  input  dreq_pkg::cfg_req_t                  cfg_req,
  output logic                                cfg_rd_valid,
  output logic [31:0]                         cfg_rd_data
);

  localparam int N_DESTS = `DREQ_N_DESTS;

  // queue heads towards the arbiter.
  logic            [N_DESTS-1:0] q_valid;
  logic            [N_DESTS-1:0] q_ready;
  dreq_pkg::dreq_t [N_DESTS-1:0] q_data;

  // side band between arbiter and config block.
  logic [N_DESTS-1:0] enable;
  dreq_pkg::grant_t   grant;

  // one request queue per destination.
  for (genvar i = 0; i < N_DESTS; i++) begin : g_queue
    dreq_in_queue inst_queue (
      .aclk    (aclk),
      .aresetn (aresetn),
      .s_valid (s_req_valid[i]),
      .s_ready (s_req_ready[i]),
      .s_data  (s_req_data[i]),
      .m_valid (q_valid[i]),
      .m_ready (q_ready[i]),
      .m_data  (q_data[i])
    );
  end

  dest_dreq_rd_arb inst_arb (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (q_valid),
    .s_ready (q_ready),
    .s_data  (q_data),
    .enable  (enable),
    .grant   (grant),
    .m_valid (m_req_valid),
    .m_ready (m_req_ready),
    .m_data  (m_req_data)
  );

  dreq_cfg_regs inst_cfg (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .cfg_strobe   (cfg_strobe),
    .cfg_req      (cfg_req),
    .cfg_rd_valid (cfg_rd_valid),
    .cfg_rd_data  (cfg_rd_data),
    .enable       (enable),
    .grant        (grant)
  );

endmodule

//--- sim/dreq_rd_mux_assert.sv
`include "dreq_params.svh"

module dreq_rd_mux_assert (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  logic [`DREQ_N_DESTS-1:0]   s_valid,
  input  logic [`DREQ_N_DESTS-1:0]   s_ready,
  input  logic [`DREQ_N_DESTS-1:0]   enable,
  input  dreq_pkg::grant_t           grant,
  input  logic                       m_valid,
  input  logic                       m_ready,
  input  dreq_pkg::dreq_tag_t        m_data
);
  timeunit 1ns;
  timeprecision 1ps;

  // a stalled output word holds until the sink takes it.
  a_out_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
    else $error("output stream changed while stalled");

  // at most one queue sees ready, and only when a grant is reported.
  a_grant_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(s_ready) && (grant.valid == (|(s_valid & s_ready))))
    else $error("grant not one-hot with the queue handshake");

  // a paused destination never wins.
  a_grant_enabled: assert property (@(posedge aclk) disable iff (!aresetn)
    grant.valid |-> enable[grant.dest])
    else $error("grant given to a disabled destination");

endmodule

bind dest_dreq_rd_arb dreq_rd_mux_assert u_arb_assert (
  .aclk    (aclk),
  .aresetn (aresetn),
  .s_valid (s_valid),
  .s_ready (s_ready),
  .enable  (enable),
  .grant   (grant),
  .m_valid (m_valid),
  .m_ready (m_ready),
  .m_data  (m_data)
);

//--- sim/tb_dreq_rd_mux.sv
`include "dreq_params.svh"

module tb_dreq_rd_mux;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N = `DREQ_N_DESTS;

  // operations a table step can carry.
  typedef enum logic [3:0] {
    OP_SEND, OP_CFG_WR, OP_CFG_RD, OP_STALL, OP_DRAIN,
    OP_IDLE, OP_CHK_PEND, OP_CHK_READY, OP_CHK_SEQ
  } op_e;

  typedef struct packed {
    op_e                        op;
    logic [`DREQ_DEST_BITS-1:0] dest;
    dreq_pkg::cfg_addr_e        addr;
    logic [31:0]                data;
    dreq_pkg::dreq_t            req;
  } step_t;

  logic                          aclk;
  logic                          aresetn;
  logic            [N-1:0]       s_req_valid;
  logic            [N-1:0]       s_req_ready;
  dreq_pkg::dreq_t [N-1:0]       s_req_data;
  logic                          m_req_valid;
  logic                          m_req_ready;
  dreq_pkg::dreq_tag_t           m_req_data;
  logic                          cfg_strobe;
  dreq_pkg::cfg_req_t            cfg_req;
  logic                          cfg_rd_valid;
  logic [31:0]                   cfg_rd_data;

  step_t           steps[$];
  // expected requests per destination, in issue order.
  dreq_pkg::dreq_t sb [N][$];
  int              seq_log[$];
  int              sent_tbl [N];
  logic [N-1:0]    enable_model;
  logic            stall_on;
  logic            table_ready;
  logic            timed_out;
  integer          seed;
  int              err_cnt;
  int              chk_cnt;
  int              out_cnt;
  int              cur_step;
  int              cycle_cnt;
  int              cycle_limit;

  dreq_rd_mux_top dut (.*);

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  // sink ready, random while stalling is on, else always high.
  always @(posedge aclk) begin
    #1;
    if (stall_on) begin
      m_req_ready = ($random(seed) & 3) != 0;
    end else begin
      m_req_ready = 1'b1;
    end
  end

  // output monitor against the per-destination scoreboard.
  always @(posedge aclk) begin
    if (aresetn && m_req_valid && m_req_ready) begin
      check_output(m_req_data);
    end
  end

  task automatic check_output(input dreq_pkg::dreq_tag_t o);
    int              d;
    dreq_pkg::dreq_t exp;
    d = int'(o.dest);
    out_cnt++;
    chk_cnt++;
    seq_log.push_back(d);
    if (!enable_model[d]) begin
      err_cnt++;
      $display("ERROR t=%0t: output came from disabled destination %0d", $time, d);
    end
    if (sb[d].size() == 0) begin
      err_cnt++;
      $display("ERROR t=%0t: extra output from destination %0d, nothing pending", $time, d);
    end else begin
      exp = sb[d].pop_front();
      if (o.req !== exp) begin
        err_cnt++;
        $display("MISMATCH t=%0t m_req_data.req[%0d] exp=%h got=%h", $time, d, exp, o.req);
      end
    end
  endtask

  // request fields follow the step index, so every entry is distinct.
  task automatic add_step(input op_e op, input int dest, input dreq_pkg::cfg_addr_e addr,
                          input logic [31:0] data);
    step_t s;
    int    k;
    k         = steps.size();
    s         = '0;
    s.op      = op;
    s.dest    = `DREQ_DEST_BITS'(dest);
    s.addr    = addr;
    s.data    = data;
    s.req.vaddr = {16'hd000 | 16'(dest), 32'(k) << 6};
    s.req.len   = 28'(k * 8 + dest + 1);
    s.req.strm  = k[0];
    s.req.last  = (k % 3) == 0;
    steps.push_back(s);
    if (op == OP_SEND) begin
      sent_tbl[dest]++;
    end
  endtask

  task automatic build_table();
    dreq_pkg::cfg_addr_e a;
    // fairness, load all queues while paused, then release.
    add_step(OP_CFG_WR, 0, dreq_pkg::REG_ENABLE, 32'h0);
    for (int k = 0; k < 3; k++) begin
      for (int d = 0; d < N; d++) begin
        add_step(OP_SEND, d, dreq_pkg::REG_ENABLE, 32'h0);
      end
    end
    add_step(OP_CFG_WR, 0, dreq_pkg::REG_ENABLE, 32'hf);
    add_step(OP_DRAIN, 0, dreq_pkg::REG_ENABLE, 32'h0);
    add_step(OP_CHK_SEQ, 0, dreq_pkg::REG_ENABLE, 32'(3 * N));
    // dest 2 paused, its queue fills and holds.
    add_step(OP_CFG_WR, 0, dreq_pkg::REG_ENABLE, 32'hb);
    for (int d = 0; d < N; d++) begin
      for (int k = 0; k < ((d == 2) ? 4 : 2); k++) begin
        add_step(OP_SEND, d, dreq_pkg::REG_ENABLE, 32'h0);
      end
    end
    add_step(OP_DRAIN, 0, dreq_pkg::REG_ENABLE, 32'h0);
    add_step(OP_IDLE, 0, dreq_pkg::REG_ENABLE, 32'd16);
    add_step(OP_CHK_PEND, 2, dreq_pkg::REG_ENABLE, 32'd4);
    add_step(OP_CHK_READY, 2, dreq_pkg::REG_ENABLE, 32'd0);
    add_step(OP_CFG_WR, 0, dreq_pkg::REG_ENABLE, 32'hf);
    add_step(OP_DRAIN, 0, dreq_pkg::REG_ENABLE, 32'h0);
    // random back-pressure on the output.
    add_step(OP_STALL, 0, dreq_pkg::REG_ENABLE, 32'd1);
    for (int k = 0; k < 3; k++) begin
      for (int d = 0; d < N; d++) begin
        add_step(OP_SEND, d, dreq_pkg::REG_ENABLE, 32'h0);
      end
    end
    add_step(OP_DRAIN, 0, dreq_pkg::REG_ENABLE, 32'h0);
    add_step(OP_STALL, 0, dreq_pkg::REG_ENABLE, 32'd0);
    // counters hold the number of requests sent per destination.
    for (int d = 0; d < N; d++) begin
      a = dreq_pkg::cfg_addr_e'(int'(dreq_pkg::REG_GRANT_CNT0) + d);
      add_step(OP_CFG_RD, 0, a, 32'(sent_tbl[d]));
    end
    add_step(OP_CFG_WR, 0, dreq_pkg::REG_GRANT_CNT1, 32'h0);
    add_step(OP_CFG_RD, 0, dreq_pkg::REG_GRANT_CNT1, 32'h0);
    add_step(OP_CFG_RD, 0, dreq_pkg::REG_GRANT_CNT0, 32'(sent_tbl[0]));
    add_step(OP_CFG_WR, 0, dreq_pkg::REG_ENABLE, 32'ha);
    add_step(OP_CFG_RD, 0, dreq_pkg::REG_ENABLE, 32'ha);
    add_step(OP_CFG_WR, 0, dreq_pkg::REG_ENABLE, 32'hf);
  endtask

  // hold valid until ready is seen, ready sampled mid-cycle.
  task automatic send_req(input int d, input dreq_pkg::dreq_t r);
    sb[d].push_back(r);
    s_req_valid[d] = 1'b1;
    s_req_data[d]  = r;
    @(negedge aclk);
    while (!s_req_ready[d]) begin
      @(negedge aclk);
    end
    @(posedge aclk);
    #1;
    s_req_valid[d] = 1'b0;
  endtask

  task automatic cfg_access(input logic wr, input dreq_pkg::cfg_addr_e a,
                            input logic [31:0] data);
    cfg_strobe   = 1'b1;
    cfg_req.wr   = wr;
    cfg_req.addr = a;
    cfg_req.data = wr ? data : 32'h0;
    if (wr && a == dreq_pkg::REG_ENABLE) begin
      enable_model = data[N-1:0];
    end
    @(posedge aclk);
    #1;
    cfg_strobe = 1'b0;
    if (!wr) begin
      // read data belongs to the cycle right after the strobe.
      chk_cnt++;
      if (cfg_rd_valid !== 1'b1) begin
        err_cnt++;
        $display("MISMATCH t=%0t cfg_rd_valid exp=1 got=%b", $time, cfg_rd_valid);
      end
      if (cfg_rd_data !== data) begin
        err_cnt++;
        $display("MISMATCH t=%0t cfg_rd_data(%s) exp=%h got=%h", $time, a.name(), data,
                 cfg_rd_data);
      end
      @(posedge aclk);
      #1;
      if (cfg_rd_valid !== 1'b0) begin
        err_cnt++;
        $display("MISMATCH t=%0t cfg_rd_valid exp=0 got=%b", $time, cfg_rd_valid);
      end
    end
  endtask

  function automatic logic drained();
    for (int d = 0; d < N; d++) begin
      if (enable_model[d] && sb[d].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic run_step(input step_t s);
    case (s.op)
      OP_SEND:   send_req(int'(s.dest), s.req);
      OP_CFG_WR: cfg_access(1'b1, s.addr, s.data);
      OP_CFG_RD: cfg_access(1'b0, s.addr, s.data);
      OP_STALL: begin
        stall_on = s.data[0];
        @(posedge aclk);
        #1;
      end
      OP_DRAIN: begin
        while (!drained()) begin
          @(posedge aclk);
          #1;
        end
      end
      OP_IDLE: begin
        repeat (s.data) begin
          @(posedge aclk);
          #1;
        end
      end
      OP_CHK_PEND: begin
        chk_cnt++;
        if (sb[s.dest].size() != int'(s.data)) begin
          err_cnt++;
          $display("MISMATCH t=%0t pending[%0d] exp=%0d got=%0d", $time, s.dest, s.data,
                   sb[s.dest].size());
        end
      end
      OP_CHK_READY: begin
        @(negedge aclk);
        chk_cnt++;
        if (s_req_ready[s.dest] !== s.data[0]) begin
          err_cnt++;
          $display("MISMATCH t=%0t s_req_ready[%0d] exp=%b got=%b", $time, s.dest, s.data[0],
                   s_req_ready[s.dest]);
        end
        @(posedge aclk);
        #1;
      end
      OP_CHK_SEQ: begin
        // round robin from 0, one step per grant.
        chk_cnt++;
        if (seq_log.size() != int'(s.data)) begin
          err_cnt++;
          $display("MISMATCH t=%0t seq_len exp=%0d got=%0d", $time, s.data, seq_log.size());
        end
        for (int k = 0; k < seq_log.size(); k++) begin
          if (seq_log[k] != k % N) begin
            err_cnt++;
            $display("MISMATCH t=%0t seq_dest[%0d] exp=%0d got=%0d", $time, k, k % N,
                     seq_log[k]);
          end
        end
        seq_log.delete();
      end
      default: begin
        err_cnt++;
        $display("ERROR t=%0t: unknown step operation", $time);
      end
    endcase
  endtask

  task automatic close_run();
    $display("checks=%0d errors=%0d outputs=%0d timeout=%0d", chk_cnt, err_cnt, out_cnt,
             timed_out);
    if (err_cnt == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  // limit scales with the table length.
  initial begin
    wait (table_ready === 1'b1);
    cycle_limit = steps.size() * 64;
    cycle_cnt   = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge aclk);
      cycle_cnt++;
    end
    timed_out = 1'b1;
    $display("ERROR: run did not finish within %0d cycles, stuck at step %0d", cycle_limit,
             cur_step);
    close_run();
  end

  initial begin
    aresetn      = 1'b0;
    s_req_valid  = '0;
    s_req_data   = '0;
    m_req_ready  = 1'b1;
    cfg_strobe   = 1'b0;
    cfg_req      = '0;
    stall_on     = 1'b0;
    enable_model = '1;
    timed_out    = 1'b0;
    seed         = 32'h43f11302;
    err_cnt      = 0;
    chk_cnt      = 0;
    out_cnt      = 0;
    cur_step     = 0;
    for (int d = 0; d < N; d++) begin
      sent_tbl[d] = 0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    for (int i = 0; i < steps.size(); i++) begin
      cur_step = i;
      run_step(steps[i]);
    end
    for (int d = 0; d < N; d++) begin
      if (sb[d].size() != 0) begin
        err_cnt++;
        $display("ERROR: %0d requests of destination %0d never came out", sb[d].size(), d);
      end
    end
    close_run();
  end

endmodule

//--- all.f
+incdir+src
src/dreq_pkg.sv
src/dreq_in_queue.sv
src/meta_reg.sv
src/dest_dreq_rd_arb.sv
src/dreq_cfg_regs.sv
src/dreq_rd_mux_top.sv
sim/dreq_rd_mux_assert.sv
sim/tb_dreq_rd_mux.sv

//--- run.sh
#!/bin/sh
# Build and run the read-request mux testbench with Verilator.
set -e

cd "$(dirname "$0")"

mkdir -p build

verilator --binary --timing --assert \
  --top-module tb_dreq_rd_mux \
  -f all.f \
  -Mdir build/obj \
  -o sim_tb

./build/obj/sim_tb > build/sim.log 2>&1
cat build/sim.log

if grep -q '\*\*\* FAILED \*\*\*' build/sim.log; then
  exit 1
fi
exit 0
